// File: bench/io_subsys_chk.sv
`timescale 1ns/1ps
`default_nettype none

module io_subsys_chk
  import io_map_pkg::*;
  import task_pkg::*;
(
  input logic       clk,
  input logic       resetq,
  input logic       io_rd,
  input io_req_t    req,
  input io_word_t   io_din,
  input gpio_pins_t pmod_pins,
  input gpio_pins_t hdr1_pins,
  input gpio_pins_t hdr2_pins,
  input kill_mask_t kill_slot_rq
);

  logic req_wr;
  logic oe_any;

  assign req_wr = req.wr;                        // Write as seen by the table
  assign oe_any = |{pmod_pins.oe, hdr1_pins.oe, hdr2_pins.oe};

  a_kill_after_wr: assert property (@(posedge clk) disable iff (!resetq)
    $changed(kill_slot_rq) |-> $past(req_wr))    // Mask moves only on a retiring write
    else $error("kill_slot_rq changed without a write request");

  a_din_idle: assert property (@(posedge clk) disable iff (!resetq)
    !$past(io_rd) |-> (io_din == '0))
    else $error("io_din nonzero after a cycle without io_rd");

  a_oe_reset: assert property (@(posedge clk) $rose(resetq) |-> !oe_any)
    else $error("output enable set right after reset");

endmodule

bind io_subsys io_subsys_chk i_io_subsys_chk (
  .clk(clk), .resetq(resetq), .io_rd(io_rd), .req(req), .io_din(io_din),
  .pmod_pins(pmod_pins), .hdr1_pins(hdr1_pins), .hdr2_pins(hdr2_pins),
  .kill_slot_rq(kill_slot_rq)
);

`default_nettype wire

// File: bench/io_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module io_subsys_tb
  import io_map_pkg::*;
  import task_pkg::*;
();

  localparam int          MAX_CYCLES   = 2000;   // Tests need roughly 150 cycles
  localparam logic [31:0] SEED         = 32'h86254233;
  localparam int          DATA_BIT [3] = '{IO_PMOD_DATA, IO_HDR1_DATA, IO_HDR2_DATA};

  logic       clk, resetq, io_rd, io_wr;
  io_sel_t    mem_addr;
  io_word_t   dout, io_din;
  slot_t      io_slot;
  gpio_byte_t pmod_in, hdr1_in, hdr2_in, leds;
  gpio_pins_t pmod_pins, hdr1_pins, hdr2_pins;
  kill_mask_t kill_slot_rq;

  gpio_pins_t [2:0] pins_now;                    // Index 0 is PMOD
  gpio_byte_t       exp_pin [3];                 // Pad levels driven
  gpio_byte_t       exp_led;
  xt_t              exp_tok [1:3];               // Expected token table
  int               cycles = 0;

  assign pins_now = {hdr2_pins, hdr1_pins, pmod_pins};

  tb_clock i_tb_clock (.clk);

  io_subsys i_io_subsys (.clk, .resetq, .io_rd, .io_wr, .mem_addr, .dout, .io_slot,
                         .pmod_in, .hdr1_in, .hdr2_in, .io_din, .pmod_pins,
                         .hdr1_pins, .hdr2_pins, .leds, .kill_slot_rq);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
    end
  end

  function automatic io_sel_t sel_bit(input int b);
    return 16'h0001 << b;                        // One-hot address
  endfunction

  function automatic io_word_t rand16();
    logic [31:0] r;
    r = $urandom;
    return r[15:0];
  endfunction

  task automatic check_eq(input string what, input io_word_t got, input io_word_t want);
    if (got !== want) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, want);
      $display("ERRORS FOUND");
      $fatal(1, "compare mismatch");
    end
  endtask

  // Returns mid-cycle once the write has landed
  task automatic write_io(input io_sel_t sel, input io_word_t data);
    @(posedge clk);
    io_wr    <= 1'b1;
    mem_addr <= sel;
    dout     <= data;
    @(posedge clk);                              // Stage takes the request
    io_wr    <= 1'b0;
    mem_addr <= '0;
    @(posedge clk);                              // Registers update
    @(negedge clk);
  endtask

  task automatic expect_read(input string what, input io_sel_t sel, input slot_t slot,
                             input io_word_t want);
    @(posedge clk);
    io_rd    <= 1'b1;
    mem_addr <= sel;
    io_slot  <= slot;
    @(posedge clk);                              // Stage takes the request
    io_rd    <= 1'b0;
    mem_addr <= '0;
    @(negedge clk);                              // Data valid one cycle later
    check_eq(what, io_din, want);
  endtask

  task automatic reset_state();
    for (int p = 0; p < 3; p++) begin
      check_eq("pins after reset", io_word_t'(pins_now[p]), '0);
    end
    check_eq("leds after reset", {8'h00, leds}, '0);
    check_eq("kill mask after reset", {12'h000, kill_slot_rq}, '0);
    for (int s = 1; s <= NUM_TASK_SLOTS; s++) begin
      expect_read("token after reset", sel_bit(IO_TASK1 + s - 1), 2'd0, '0);
    end
  endtask

  task automatic gpio_ports();
    io_word_t data_w;
    io_word_t dir_w;
    for (int p = 0; p < 3; p++) begin
      data_w = rand16();
      dir_w  = rand16();
      write_io(sel_bit(DATA_BIT[p]), data_w);
      write_io(sel_bit(DATA_BIT[p] + 1), dir_w); // Dir sits one above data
      check_eq("gpio pins", io_word_t'(pins_now[p]), {data_w[7:0], dir_w[7:0]});
      expect_read("gpio dir read", sel_bit(DATA_BIT[p] + 1), 2'd0, {8'h00, dir_w[7:0]});
      data_w     = rand16();
      exp_pin[p] = data_w[7:0];
    end
    @(posedge clk);
    pmod_in <= exp_pin[0];                       // Pads differ from out regs
    hdr1_in <= exp_pin[1];
    hdr2_in <= exp_pin[2];
    for (int p = 0; p < 3; p++) begin
      expect_read("gpio pad read", sel_bit(DATA_BIT[p]), 2'd0, {8'h00, exp_pin[p]});
    end
    data_w  = rand16();
    exp_led = data_w[7:0];
    write_io(sel_bit(IO_LEDS), data_w);
    check_eq("leds", {8'h00, leds}, {8'h00, exp_led});
    expect_read("led read", sel_bit(IO_LEDS), 2'd0, {8'h00, exp_led});
  endtask

  task automatic task_table_rw();
    for (int s = 1; s <= NUM_TASK_SLOTS; s++) begin
      exp_tok[s] = rand16() & 16'hFFFE;          // Plain even token
      write_io(sel_bit(IO_TASK1 + s - 1), exp_tok[s]);
    end
    for (int s = 1; s <= NUM_TASK_SLOTS; s++) begin
      expect_read("token read", sel_bit(IO_TASK1 + s - 1), 2'd0, exp_tok[s]);
      expect_read("slot 0 fetch", sel_bit(IO_TASK_FETCH), 2'd0, '0);
      expect_read("own fetch", sel_bit(IO_TASK_FETCH), slot_t'(s), exp_tok[s]);
      expect_read("repeat fetch", sel_bit(IO_TASK_FETCH), slot_t'(s), exp_tok[s]);
    end
  endtask

  task automatic run_once_clear();
    exp_tok[2] = rand16() | 16'h0001;            // Run-once flag
    write_io(sel_bit(IO_TASK2), exp_tok[2]);
    expect_read("foreign fetch", sel_bit(IO_TASK_FETCH), 2'd3, exp_tok[3]);
    expect_read("token after foreign fetch", sel_bit(IO_TASK2), 2'd0, exp_tok[2]);
    expect_read("run-once fetch", sel_bit(IO_TASK_FETCH), 2'd2, exp_tok[2] & 16'hFFFE);
    exp_tok[2] = '0;                             // Gone after its own fetch
    expect_read("fetch after clear", sel_bit(IO_TASK_FETCH), 2'd2, '0);
    expect_read("token after clear", sel_bit(IO_TASK2), 2'd0, '0);
  endtask

  task automatic kill_mask_update();
    io_word_t data_w;
    data_w = rand16() | 16'h0001;                // Never an empty mask
    write_io(sel_bit(IO_TASK_FETCH), data_w);
    check_eq("kill mask", {12'h000, kill_slot_rq}, {12'h000, data_w[3:0]});
    expect_read("slot id", sel_bit(IO_SLOT_ID), 2'd1, 16'd1);
    expect_read("led read", sel_bit(IO_LEDS), 2'd0, {8'h00, exp_led});
    check_eq("kill mask over reads", {12'h000, kill_slot_rq}, {12'h000, data_w[3:0]});
    write_io(sel_bit(IO_TASK1), exp_tok[1]);     // Other write drops the mask
    check_eq("kill mask cleared", {12'h000, kill_slot_rq}, '0);
  endtask

  task automatic read_combine();
    io_word_t want;
    want = {8'h00, exp_led} | {8'h00, exp_pin[1]} | exp_tok[1] | 16'd2;
    expect_read("combined read", sel_bit(IO_LEDS) | sel_bit(IO_HDR1_DATA) | sel_bit(IO_TASK1)
                | sel_bit(IO_SLOT_ID), 2'd2, want);
    expect_read("fetch with pad", sel_bit(IO_TASK_FETCH) | sel_bit(IO_PMOD_DATA), 2'd3,
                exp_tok[3] | {8'h00, exp_pin[0]});
    expect_read("unused bits", sel_bit(3) | sel_bit(11) | sel_bit(12) | sel_bit(13), 2'd1, '0);
    for (int s = 0; s < 4; s++) begin
      expect_read("slot id", sel_bit(IO_SLOT_ID), slot_t'(s), io_word_t'(s));
    end
  endtask

  initial begin
    void'($urandom(SEED));                       // One seed for the whole run
    resetq <= 1'b0;
    {io_rd, io_wr, mem_addr, dout, io_slot} <= '0;
    {pmod_in, hdr1_in, hdr2_in} <= '0;
    repeat (5) @(posedge clk);
    resetq <= 1'b1;
    @(negedge clk);
    reset_state();
    gpio_ports();
    task_table_rw();
    run_once_clear();
    kill_mask_update();
    read_combine();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  localparam int HALF_PERIOD = 50;               // 100 ns period

  initial clk = 1'b0;

  always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: common/io_map_pkg.sv
`default_nettype none

package io_map_pkg;

  localparam int IO_W        = 16;     // Processor I/O data width
  localparam int SLOT_W      = 2;      // Four hardware slots
  localparam int GPIO_W      = 8;
  localparam int GPIO_RD_WORDS = 7;    // Three ports of data and dir plus LEDs

  // One-hot I/O address bit positions
  localparam int IO_PMOD_DATA  = 0;
  localparam int IO_PMOD_DIR   = 1;
  localparam int IO_LEDS       = 2;
  localparam int IO_HDR1_DATA  = 4;
  localparam int IO_HDR1_DIR   = 5;
  localparam int IO_HDR2_DATA  = 6;
  localparam int IO_HDR2_DIR   = 7;
  localparam int IO_TASK1      = 8;    // Slots 2 and 3 follow at 9 and 10
  localparam int IO_TASK2      = 9;
  localparam int IO_TASK3      = 10;
  localparam int IO_TASK_FETCH = 14;   // Read fetches own token, write kills
  localparam int IO_SLOT_ID    = 15;

  typedef logic [IO_W-1:0]   io_word_t;
  typedef logic [IO_W-1:0]   io_sel_t;   // One bit per device
  typedef logic [SLOT_W-1:0] slot_t;
  typedef logic [GPIO_W-1:0] gpio_byte_t;

  typedef struct packed {
    logic     rd;
    logic     wr;
    io_sel_t  sel;                       // Zero on idle cycles
    io_word_t data;
    slot_t    slot;
  } io_req_t;

  typedef struct packed {
    gpio_byte_t out;
    gpio_byte_t oe;                      // 1 drives the pin
  } gpio_pins_t;

endpackage

`default_nettype wire

// File: common/task_pkg.sv
`default_nettype none

package task_pkg;

  // Slot 0 runs the shell and never gets a token
  localparam int NUM_TASK_SLOTS = 3;

  localparam int XT_W = 16;

  // Valid tokens are even
  // Bit 0 set marks a run-once task
  typedef logic [XT_W-1:0] xt_t;

  // Bit n requests a kill of slot n
  typedef logic [NUM_TASK_SLOTS:0] kill_mask_t;

endpackage

`default_nettype wire

// File: gpio/gpio_bank.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_bank import io_map_pkg::*; (
  input  logic                            clk,
  input  logic                            resetq,
  input  io_req_t                         req,
  input  gpio_byte_t                      pmod_in,
  input  gpio_byte_t                      hdr1_in,
  input  gpio_byte_t                      hdr2_in,
  output gpio_pins_t                      pmod_pins,
  output gpio_pins_t                      hdr1_pins,
  output gpio_pins_t                      hdr2_pins,
  output gpio_byte_t                      leds,
  output gpio_byte_t [GPIO_RD_WORDS-1:0]  gpio_rd
);

  gpio_byte_t wr_byte;
  gpio_byte_t pmod_q;
  gpio_byte_t pmod_dir;                          // 1 is output
  gpio_byte_t hdr1_q;
  gpio_byte_t hdr1_dir;
  gpio_byte_t hdr2_q;
  gpio_byte_t hdr2_dir;

  assign wr_byte = req.data[GPIO_W-1:0];         // Ports take the low byte

  always_ff @(posedge clk) begin
    if (!resetq) begin
      pmod_q   <= '0;                            // All pins start as inputs
      pmod_dir <= '0;
      hdr1_q   <= '0;
      hdr1_dir <= '0;
      hdr2_q   <= '0;
      hdr2_dir <= '0;
      leds     <= '0;
    end else if (req.wr) begin
      if (req.sel[IO_PMOD_DATA]) pmod_q   <= wr_byte;
      if (req.sel[IO_PMOD_DIR])  pmod_dir <= wr_byte;
      if (req.sel[IO_LEDS])      leds     <= wr_byte;
      if (req.sel[IO_HDR1_DATA]) hdr1_q   <= wr_byte;
      if (req.sel[IO_HDR1_DIR])  hdr1_dir <= wr_byte;
      if (req.sel[IO_HDR2_DATA]) hdr2_q   <= wr_byte;
      if (req.sel[IO_HDR2_DIR])  hdr2_dir <= wr_byte;
    end
  end

  assign pmod_pins = '{out: pmod_q, oe: pmod_dir};
  assign hdr1_pins = '{out: hdr1_q, oe: hdr1_dir};
  assign hdr2_pins = '{out: hdr2_q, oe: hdr2_dir};

  // Data addresses read the pads and not the output register
  assign gpio_rd = {
    hdr2_dir,                                    // [6]
    hdr2_in,
    hdr1_dir,
    hdr1_in,                                     // [3]
    leds,
    pmod_dir,
    pmod_in                                      // [0]
  };

endmodule

`default_nettype wire

// File: io_subsys.f
common/io_map_pkg.sv
common/task_pkg.sv
source/io_bus_stage.sv
task_sched/task_slot_table.sv
gpio/gpio_bank.sv
source/io_read_select.sv
source/io_subsys.sv
bench/tb_clock.sv
bench/io_subsys_chk.sv
bench/io_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the log says so
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module io_subsys_tb -f io_subsys.f \
  -o io_subsys_sim
./obj_dir/io_subsys_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "NO ERRORS" sim.log

// File: source/io_bus_stage.sv
`timescale 1ns/1ps
`default_nettype none

module io_bus_stage import io_map_pkg::*; (
  input  logic     clk,
  input  logic     resetq,
  input  logic     io_rd,
  input  logic     io_wr,
  input  io_sel_t  mem_addr,
  input  io_word_t dout,
  input  slot_t    io_slot,
  output io_req_t  req
);

  logic     rd_q;
  logic     wr_q;
  io_sel_t  sel_q;
  io_word_t data_q;
  slot_t    slot_q;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      rd_q  <= 1'b0;
      wr_q  <= 1'b0;
      sel_q <= '0;
    end else begin
      rd_q  <= io_rd;
      wr_q  <= io_wr;
      sel_q <= (io_rd | io_wr) ? mem_addr : '0;  // No access selects nothing
    end
  end

  always_ff @(posedge clk) begin
    data_q <= dout;                             // Write payload
    slot_q <= io_slot;                          // Slot that issued it
  end

  assign req = '{rd: rd_q, wr: wr_q, sel: sel_q, data: data_q, slot: slot_q};

endmodule

`default_nettype wire

// File: source/io_read_select.sv
`timescale 1ns/1ps
`default_nettype none

module io_read_select
  import io_map_pkg::*;
  import task_pkg::*;
(
  input  io_req_t                         req,
  input  gpio_byte_t [GPIO_RD_WORDS-1:0]  gpio_rd,
  input  xt_t [NUM_TASK_SLOTS-1:0]        task_words,
  input  xt_t                             fetch_word,
  output io_word_t                        io_din
);

  function automatic io_word_t gate_byte(input gpio_byte_t val, input logic en);
    gate_byte = en ? io_word_t'(val) : '0;       // Zero-extend
  endfunction

  io_word_t rd_or;

  always_comb begin
    rd_or = '0;
    rd_or |= gate_byte(gpio_rd[0], req.sel[IO_PMOD_DATA]);
    rd_or |= gate_byte(gpio_rd[1], req.sel[IO_PMOD_DIR]);
    rd_or |= gate_byte(gpio_rd[2], req.sel[IO_LEDS]);
    rd_or |= gate_byte(gpio_rd[3], req.sel[IO_HDR1_DATA]);
    rd_or |= gate_byte(gpio_rd[4], req.sel[IO_HDR1_DIR]);
    rd_or |= gate_byte(gpio_rd[5], req.sel[IO_HDR2_DATA]);
    rd_or |= gate_byte(gpio_rd[6], req.sel[IO_HDR2_DIR]);
    for (int i = 0; i < NUM_TASK_SLOTS; i++) begin
      if (req.sel[IO_TASK1 + i]) begin
        rd_or |= task_words[i];                  // Raw token with run-once flag
      end
    end
    if (req.sel[IO_TASK_FETCH]) begin
      rd_or |= fetch_word;
    end
    if (req.sel[IO_SLOT_ID]) begin
      rd_or |= io_word_t'(req.slot);
    end
  end

  assign io_din = req.rd ? rd_or : '0;           // Writes return nothing

endmodule

`default_nettype wire

// File: source/io_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module io_subsys
  import io_map_pkg::*;
  import task_pkg::*;
(
  input  logic       clk,
  input  logic       resetq,
  input  logic       io_rd,
  input  logic       io_wr,
  input  io_sel_t    mem_addr,
  input  io_word_t   dout,
  input  slot_t      io_slot,
  input  gpio_byte_t pmod_in,
  input  gpio_byte_t hdr1_in,
  input  gpio_byte_t hdr2_in,
  output io_word_t   io_din,
  output gpio_pins_t pmod_pins,
  output gpio_pins_t hdr1_pins,
  output gpio_pins_t hdr2_pins,
  output gpio_byte_t leds,
  output kill_mask_t kill_slot_rq
);

  io_req_t                        req;           // Registered request
  xt_t [NUM_TASK_SLOTS-1:0]       task_words;
  xt_t                            fetch_word;
  gpio_byte_t [GPIO_RD_WORDS-1:0] gpio_rd;

  io_bus_stage i_io_bus_stage (.clk, .resetq, .io_rd, .io_wr, .mem_addr, .dout,
                               .io_slot, .req);

  task_slot_table i_task_slot_table (.clk, .resetq, .req, .task_words, .fetch_word,
                                     .kill_slot_rq);

  gpio_bank i_gpio_bank (.clk, .resetq, .req, .pmod_in, .hdr1_in, .hdr2_in,
                         .pmod_pins, .hdr1_pins, .hdr2_pins, .leds, .gpio_rd);

  io_read_select i_io_read_select (.req, .gpio_rd, .task_words, .fetch_word,
                                   .io_din);

endmodule

`default_nettype wire

// File: task_sched/task_slot_table.sv
`timescale 1ns/1ps
`default_nettype none

module task_slot_table
  import io_map_pkg::*;
  import task_pkg::*;
(
  input  logic                     clk,
  input  logic                     resetq,
  input  io_req_t                  req,
  output xt_t [NUM_TASK_SLOTS-1:0] task_words,   // Index 0 is slot 1
  output xt_t                      fetch_word,
  output kill_mask_t               kill_slot_rq
);

  logic fetch_rd;

  assign fetch_rd = req.rd & req.sel[IO_TASK_FETCH];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      task_words   <= '0;                          // Stops every slot
      kill_slot_rq <= '0;
    end else if (req.wr) begin
      // Any slot may schedule any other
      for (int i = 0; i < NUM_TASK_SLOTS; i++) begin
        if (req.sel[IO_TASK1 + i]) begin
          task_words[i] <= req.data;
        end
      end
      // Every write refreshes the mask
      if (req.sel[IO_TASK_FETCH]) begin
        kill_slot_rq <= req.data[$bits(kill_mask_t)-1:0];
      end else begin
        kill_slot_rq <= '0;
      end
    end else if (fetch_rd) begin
      for (int i = 0; i < NUM_TASK_SLOTS; i++) begin
        // Run-once token dies after its own slot fetches it
        if (req.slot == slot_t'(i + 1) && task_words[i][0]) begin
          task_words[i] <= '0;
        end
      end
    end
  end

  always_comb begin
    fetch_word = '0;                               // Slot 0 always fetches zero
    for (int i = 0; i < NUM_TASK_SLOTS; i++) begin
      if (req.slot == slot_t'(i + 1)) begin
        fetch_word = {task_words[i][$bits(xt_t)-1:1], 1'b0};  // Hide run-once flag
      end
    end
  end

endmodule

`default_nettype wire
